// ==== flist.f ====
+incdir+.
fpalu_pkg.sv
fpalu_add_path.sv
fpalu_booth_mul.sv
fpalu_normalize.sv
fpalu_top.sv
fpalu_chk.sv
tb_fpalu.sv

// ==== fpalu_add_path.sv ====
// Wide add path of the FPALU, aligns and adds or subtracts two operands in two stages
`timescale 1ns/1ps
`default_nettype none

`include "fpalu_params.svh"

module fpalu_add_path import fpalu_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	input  logic op_mul,        // Add path only takes op_mul == 0
	input  logic a_sgn,
	input  exp_t a_exp,
	input  man_t a_man,
	input  logic b_sgn,
	input  exp_t b_exp,
	input  man_t b_man,
	output logic add_valid,
	output logic add_sgn,
	output exp_t add_exp,       // Base exponent, reference for the normalizer
	output sum_t add_sum        // Magnitude, 23 bits
);

	// Exponent compare by borrow
	logic [`FPALU_EXP_W:0] exp_diff;
	logic                  a_lt_b;      // b is the base
	exp_t                  shamt;       // |ea - eb|
	logic                  shift_far;   // Whole mantissa shifted out
	man_t                  swap_lo;     // Smaller-exponent mantissa
	man_t                  aligned;
	logic                  a_zero;
	logic                  b_zero;

	// Stage 1 inputs
	man_t base_man;
	man_t aln_man;
	exp_t base_exp;
	logic base_sgn;
	logic oth_sgn;
	logic eff_sub;

	assign exp_diff  = {1'b0, a_exp} - {1'b0, b_exp};
	assign a_lt_b    = exp_diff[`FPALU_EXP_W];                       // Borrow out
	assign shamt     = a_lt_b ? (b_exp - a_exp) : exp_diff[`FPALU_EXP_W-1:0];
	assign shift_far = (shamt >= exp_t'(`FPALU_MAN_W));
	assign swap_lo   = a_lt_b ? a_man : b_man;
	assign aligned   = shift_far ? '0 : (swap_lo >> shamt);          // Truncating shift
	assign a_zero    = (a_man == '0);
	assign b_zero    = (b_man == '0);

	always_comb begin
		oth_sgn = a_lt_b ? a_sgn : b_sgn;
		if (a_zero) begin
			// b passes through untouched, exponent included
			base_man = b_man;
			base_exp = b_exp;
			base_sgn = b_sgn;
			aln_man  = '0;
			eff_sub  = 1'b0;
		end else if (b_zero) begin
			base_man = a_man;
			base_exp = a_exp;
			base_sgn = a_sgn;
			aln_man  = '0;
			eff_sub  = 1'b0;
		end else begin
			base_man = a_lt_b ? b_man : a_man;   // Ties keep a as base
			base_exp = a_lt_b ? b_exp : a_exp;
			base_sgn = a_lt_b ? b_sgn : a_sgn;
			aln_man  = aligned;
			eff_sub  = a_sgn ^ b_sgn;            // Signs differ, subtract
		end
	end

	// Stage 1 registers
	logic s1_valid;
	man_t s1_base_man;
	man_t s1_aln_man;
	exp_t s1_base_exp;
	logic s1_base_sgn;
	logic s1_oth_sgn;
	logic s1_sub;

	always_ff @(posedge clk) begin
		if (rst)
			s1_valid <= 1'b0;
		else
			s1_valid <= in_valid & ~op_mul;
	end

	always_ff @(posedge clk) begin
		if (in_valid && !op_mul) begin // Hold on multiplies
			s1_base_man <= base_man;
			s1_aln_man  <= aln_man;
			s1_base_exp <= base_exp;
			s1_base_sgn <= base_sgn;
			s1_oth_sgn  <= oth_sgn;
			s1_sub      <= eff_sub;
		end
	end

	// Magnitude add or subtract
	sum_t mag_add;
	sum_t mag_sub;
	logic sub_neg;

	assign mag_add = {1'b0, s1_base_man} + {1'b0, s1_aln_man};
	assign mag_sub = {1'b0, s1_base_man} - {1'b0, s1_aln_man};
	assign sub_neg = mag_sub[`FPALU_SUM_W-1];   // Aligned operand was larger

	always_ff @(posedge clk) begin
		if (rst)
			add_valid <= 1'b0;
		else
			add_valid <= s1_valid;
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			add_exp <= s1_base_exp;
			if (!s1_sub) begin
				add_sum <= mag_add;
				add_sgn <= s1_base_sgn;
			end else if (sub_neg) begin
				add_sum <= -mag_sub;            // Two's complement back to magnitude
				add_sgn <= s1_oth_sgn;
			end else begin
				add_sum <= mag_sub;
				add_sgn <= s1_base_sgn;
			end
		end
	end

endmodule

`default_nettype wire

// ==== fpalu_booth_mul.sv ====
// Half multiply path of the FPALU, radix-4 Booth product of two half significands in two stages
`timescale 1ns/1ps
`default_nettype none

`include "fpalu_params.svh"

module fpalu_booth_mul import fpalu_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	input  logic op_mul,        // Multiply path only takes op_mul == 1
	input  logic a_sgn,
	input  exp_t a_exp,         // Low 5 bits used
	input  man_t a_man,         // Low 10 bits used
	input  logic b_sgn,
	input  exp_t b_exp,
	input  man_t b_man,
	output logic mul_valid,
	output logic mul_sgn,
	output exp_t mul_exp,       // ea + eb + 3
	output sum_t mul_sum        // Product P, top bit always 0
);

	localparam int PP_W   = `FPALU_H_FRAC_W + 2;  // Holds 2 * significand
	localparam int N_PP   = 6;                     // 11-bit multiplier, padded
	localparam int MULT_W = 2 * N_PP + 1;

	typedef logic [`FPALU_H_EXP_W-1:0] hexp_t;

	hexp_t ea_raw;
	hexp_t eb_raw;
	hexp_t ea_eff;
	hexp_t eb_eff;
	hsig_t sig_a;
	hsig_t sig_b;

	assign ea_raw = a_exp[`FPALU_H_EXP_W-1:0];
	assign eb_raw = b_exp[`FPALU_H_EXP_W-1:0];

	// Subnormal, no hidden bit and exponent counts as 1
	assign sig_a  = {(ea_raw != '0), a_man[`FPALU_H_FRAC_W-1:0]};
	assign sig_b  = {(eb_raw != '0), b_man[`FPALU_H_FRAC_W-1:0]};
	assign ea_eff = (ea_raw == '0) ? hexp_t'(1) : ea_raw;
	assign eb_eff = (eb_raw == '0) ? hexp_t'(1) : eb_raw;

	// Multiplier with a zero below and a zero on top, top digit never negative
	logic [MULT_W-1:0] mult;
	logic [PP_W-1:0]   pp [N_PP];
	logic [N_PP-1:0]   pp_neg;

	assign mult = {1'b0, sig_b, 1'b0};

	always_comb begin
		logic [2:0]      grp;
		logic [PP_W-1:0] mag;
		for (int i = 0; i < N_PP; i++) begin
			grp = mult[2*i +: 3];
			case (grp)
				3'b001, 3'b010, 3'b101, 3'b110: mag = {1'b0, sig_a};  // +-A
				3'b011, 3'b100:                 mag = {sig_a, 1'b0};  // +-2A
				default:                        mag = '0;             // 000, 111
			endcase
			pp_neg[i] = grp[2] & ~(grp[1] & grp[0]); // 111 is +0
			pp[i]     = pp_neg[i] ? ~mag : mag;      // One's complement, +1 added later
		end
	end

	// Stage 1 registers
	logic            s1_valid;
	logic [PP_W-1:0] s1_pp [N_PP];
	logic [N_PP-1:0] s1_neg;
	hexp_t           s1_ea;
	hexp_t           s1_eb;
	logic            s1_sgn;

	always_ff @(posedge clk) begin
		if (rst)
			s1_valid <= 1'b0;
		else
			s1_valid <= in_valid & op_mul;
	end

	always_ff @(posedge clk) begin
		if (in_valid && op_mul) begin  // Hold on adds
			s1_pp  <= pp;
			s1_neg <= pp_neg;
			s1_ea  <= ea_eff;
			s1_eb  <= eb_eff;
			s1_sgn <= a_sgn ^ b_sgn;
		end
	end

	// Sign extend a partial product, weight it, add its correction bit
	function automatic man_t place_pp(input logic [PP_W-1:0] p, input logic neg,
			input int sh);
		man_t ext;
		ext = {{(`FPALU_MAN_W - PP_W){neg}}, p};
		return (ext << sh) + (man_t'(neg) << sh);
	endfunction

	// Sums wrap modulo 2^22, exact since the product fits
	man_t grp_lo;
	man_t grp_hi;
	man_t prod;

	assign grp_lo = place_pp(s1_pp[0], s1_neg[0], 0)
		+ place_pp(s1_pp[1], s1_neg[1], 2)
		+ place_pp(s1_pp[2], s1_neg[2], 4);
	assign grp_hi = place_pp(s1_pp[3], s1_neg[3], 6)
		+ place_pp(s1_pp[4], s1_neg[4], 8)
		+ place_pp(s1_pp[5], s1_neg[5], 10);
	assign prod   = grp_lo + grp_hi; // Final add

	always_ff @(posedge clk) begin
		if (rst)
			mul_valid <= 1'b0;
		else
			mul_valid <= s1_valid;
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			mul_sum <= {1'b0, prod};
			mul_exp <= {1'b0, s1_ea} + {1'b0, s1_eb} + exp_t'(3); // Rebias to wide
			mul_sgn <= s1_sgn;
		end
	end

endmodule

`default_nettype wire

// ==== fpalu_chk.sv ====
// Assertion checker bound into fpalu_top, watches reset, fixed latency and output form
`timescale 1ns/1ps
`default_nettype none

`include "fpalu_params.svh"

module fpalu_chk import fpalu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic out_valid,
	input logic y_sgn,
	input exp_t y_exp,
	input man_t y_man
);

	// Pipeline empty one cycle into reset
	reset_clears: assert property (@(posedge clk) rst |=> !out_valid)
		else $error("out_valid high after a reset cycle");

	// One output per input, fixed delay
	fixed_latency: assert property (@(posedge clk) disable iff (rst)
		out_valid == $past(in_valid, `FPALU_LAT))
		else $error("out_valid does not follow in_valid by the pipeline latency");

	zero_form: assert property (@(posedge clk) disable iff (rst)
		(out_valid && y_man == '0) |-> (!y_sgn && y_exp == '0))
		else $error("zero mantissa with nonzero sign or exponent");

	// Normalized, MSB set
	normalized: assert property (@(posedge clk) disable iff (rst)
		(out_valid && y_man != '0) |-> y_man[`FPALU_MAN_W-1])
		else $error("nonzero mantissa without its top bit set");

endmodule

bind fpalu_top fpalu_chk u_chk (
	.clk       (clk),
	.rst       (rst),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.y_sgn     (y_sgn),
	.y_exp     (y_exp),
	.y_man     (y_man)
);

`default_nettype wire

// ==== fpalu_normalize.sv ====
// Shared FPALU normalizer, picks the valid path result and left-justifies it in two stages
`timescale 1ns/1ps
`default_nettype none

`include "fpalu_params.svh"

module fpalu_normalize import fpalu_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic add_valid,
	input  logic add_sgn,
	input  exp_t add_exp,
	input  sum_t add_sum,
	input  logic mul_valid,
	input  logic mul_sgn,
	input  exp_t mul_exp,
	input  sum_t mul_sum,
	output logic out_valid,
	output logic y_sgn,
	output exp_t y_exp,
	output man_t y_man        // Top bit set unless the result is zero
);

	// Priority encoder from the MSB, 23 for an all-zero input
	function automatic lz_t count_lz(input sum_t v);
		lz_t  n;
		logic hit;
		n   = '0;
		hit = 1'b0;
		for (int i = `FPALU_SUM_W - 1; i >= 0; i--) begin
			if (!hit) begin
				if (v[i])
					hit = 1'b1;
				else
					n = n + lz_t'(1);
			end
		end
		return n;
	endfunction

	// Path select, the two valids never overlap
	logic sel_valid;
	logic sel_sgn;
	exp_t sel_exp;
	sum_t sel_sum;

	assign sel_valid = add_valid | mul_valid;
	assign sel_sgn   = add_valid ? add_sgn : mul_sgn;
	assign sel_exp   = add_valid ? add_exp : mul_exp;
	assign sel_sum   = add_valid ? add_sum : mul_sum;

	// Stage 3 registers
	logic s3_valid;
	logic s3_sgn;
	exp_t s3_exp;
	sum_t s3_sum;
	lz_t  s3_lz;
	logic s3_zero;

	always_ff @(posedge clk) begin
		if (rst)
			s3_valid <= 1'b0;
		else
			s3_valid <= sel_valid;
	end

	always_ff @(posedge clk) begin
		if (sel_valid) begin
			s3_sgn  <= sel_sgn;
			s3_exp  <= sel_exp;
			s3_sum  <= sel_sum;
			s3_lz   <= count_lz(sel_sum);
			s3_zero <= (sel_sum == '0);
		end
	end

	// Left shift, keep the top 22 bits
	sum_t shifted;

	assign shifted = s3_sum << s3_lz;

	always_ff @(posedge clk) begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= s3_valid;
	end

	always_ff @(posedge clk) begin
		if (s3_valid) begin
			if (s3_zero) begin
				// Canonical zero
				y_sgn <= 1'b0;
				y_exp <= '0;
				y_man <= '0;
			end else begin
				y_sgn <= s3_sgn;
				y_exp <= s3_exp + exp_t'(1) - {1'b0, s3_lz}; // Drop of the LSB adds one
				y_man <= shifted[`FPALU_SUM_W-1:1];
			end
		end
	end

endmodule

`default_nettype wire

// ==== fpalu_params.svh ====
// Width and latency macros of the FPALU, included by the package and the testbench
`ifndef FPALU_PARAMS_SVH
`define FPALU_PARAMS_SVH

// Wide format, value = man * 2^(exp - 53)
`define FPALU_EXP_W 6
`define FPALU_MAN_W 22

// Path result before normalization, one carry bit above the mantissa
`define FPALU_SUM_W 23

// Half format inputs of the multiplier
`define FPALU_H_EXP_W 5
`define FPALU_H_FRAC_W 10

// Leading-zero count, covers 0..23
`define FPALU_LZ_W 5

// Input to output, in clock cycles
// Two cycles in either path, two in the normalizer
`define FPALU_LAT 4

`endif

// ==== fpalu_pkg.sv ====
// Vector types shared by the FPALU datapath, imported by each RTL module that needs them
`default_nettype none

`include "fpalu_params.svh"

package fpalu_pkg;

	// Wide exponent, also the reference exponent of a path result
	typedef logic [`FPALU_EXP_W-1:0] exp_t;

	// Wide mantissa, right aligned
	typedef logic [`FPALU_MAN_W-1:0] man_t;

	// Unnormalized magnitude
	// Carry of the wide add lands in the top bit
	typedef logic [`FPALU_SUM_W-1:0] sum_t;

	// Half significand with the hidden bit
	typedef logic [`FPALU_H_FRAC_W:0] hsig_t;

	// Leading-zero count of a sum_t
	typedef logic [`FPALU_LZ_W-1:0] lz_t;

endpackage

`default_nettype wire

// ==== fpalu_top.sv ====
// FPALU top level, wide add and half multiply paths feeding one normalizer, latency 4
`timescale 1ns/1ps
`default_nettype none

module fpalu_top import fpalu_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	input  logic op_mul,        // 1 multiply, 0 add
	input  logic a_sgn,
	input  exp_t a_exp,
	input  man_t a_man,
	input  logic b_sgn,
	input  exp_t b_exp,
	input  man_t b_man,
	output logic out_valid,
	output logic y_sgn,
	output exp_t y_exp,
	output man_t y_man
);

	// Add path to normalizer
	logic add_valid;
	logic add_sgn;
	exp_t add_exp;
	sum_t add_sum;

	// Multiply path to normalizer
	logic mul_valid;
	logic mul_sgn;
	exp_t mul_exp;
	sum_t mul_sum;

	fpalu_add_path u_add (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.op_mul    (op_mul),
		.a_sgn     (a_sgn),
		.a_exp     (a_exp),
		.a_man     (a_man),
		.b_sgn     (b_sgn),
		.b_exp     (b_exp),
		.b_man     (b_man),
		.add_valid (add_valid),
		.add_sgn   (add_sgn),
		.add_exp   (add_exp),
		.add_sum   (add_sum)
	);

	fpalu_booth_mul u_mul (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.op_mul    (op_mul),
		.a_sgn     (a_sgn),
		.a_exp     (a_exp),
		.a_man     (a_man),
		.b_sgn     (b_sgn),
		.b_exp     (b_exp),
		.b_man     (b_man),
		.mul_valid (mul_valid),
		.mul_sgn   (mul_sgn),
		.mul_exp   (mul_exp),
		.mul_sum   (mul_sum)
	);

	fpalu_normalize u_norm (
		.clk       (clk),
		.rst       (rst),
		.add_valid (add_valid),
		.add_sgn   (add_sgn),
		.add_exp   (add_exp),
		.add_sum   (add_sum),
		.mul_valid (mul_valid),
		.mul_sgn   (mul_sgn),
		.mul_exp   (mul_exp),
		.mul_sum   (mul_sum),
		.out_valid (out_valid),
		.y_sgn     (y_sgn),
		.y_exp     (y_exp),
		.y_man     (y_man)
	);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build the FPALU testbench with Verilator, run it and look for the pass line
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f flist.f --top-module tb_fpalu \
	-Mdir obj_dir -o sim_fpalu

# An assertion stop exits nonzero, the search below still decides
out="$(./obj_dir/sim_fpalu 2>&1)" || true
printf '%s\n' "$out"

if grep -q "TB PASSED" <<< "$out"; then
	exit 0
fi

echo "Simulation did not report a pass"
exit 1

// ==== tb_fpalu.sv ====
// Self-checking testbench of fpalu_top, drives random adds and multiplies and compares in order
`timescale 1ns/1ps
`default_nettype none

`include "fpalu_params.svh"

module tb_fpalu import fpalu_pkg::*; ();

	localparam int N_TESTS = 5;
	localparam int N_ITEMS = 200;
	localparam int RES_W   = 1 + `FPALU_EXP_W + `FPALU_MAN_W;   // {sgn, exp, man}
	// Items and drain per test, then reset and the idle gaps of the mixed test
	localparam int TIMEOUT_CYC = N_TESTS * (N_ITEMS + 2 * `FPALU_LAT) + 160;

	logic clk;
	logic rst;
	logic in_valid;
	logic op_mul;
	logic a_sgn;
	exp_t a_exp;
	man_t a_man;
	logic b_sgn;
	exp_t b_exp;
	man_t b_man;
	logic out_valid;
	logic y_sgn;
	exp_t y_exp;
	man_t y_man;

	int               seed;
	int               cyc;         // Rising edges since start
	int               err_cnt;
	int               chk_cnt;
	int               errs_before;
	logic [RES_W-1:0] exp_q[$];    // Expected results, oldest first
	int               iss_q[$];    // Cycle each item was driven
	logic [RES_W-1:0] exp_item;
	int               exp_cyc;

	fpalu_top uut (.*);

	always #5 clk = ~clk;

	function automatic int urange(input int lo, input int hi);
		return lo + (($random(seed) & 32'h7fff_ffff) % (hi - lo + 1));
	endfunction

	function automatic man_t rand_man();
		man_t m;
		m = man_t'($random(seed));
		if (m == '0)
			m = man_t'(1);                  // Zeros only where a test asks
		return m;
	endfunction

	function automatic string test_name(input int t);
		case (t)
			1:       return "add, equal signs";
			2:       return "add, opposite signs";
			3:       return "add, zero bypass";
			4:       return "half multiply";
			default: return "mixed stream with gaps";
		endcase
	endfunction

	// Expected {sgn, exp, man} straight from the number format rules
	function automatic logic [RES_W-1:0] expect_result(input logic op, input logic as,
			input exp_t ae, input man_t am, input logic bs, input exp_t be, input man_t bm);
		logic [22:0] r;
		logic [22:0] sh;
		logic        s;
		logic        big_s;
		logic        small_s;
		exp_t        e;
		int          big_m;
		int          small_m;
		int          diff;
		int          d;
		int          lz;
		int          sa_i;
		int          sb_i;
		int          eaf;
		int          ebf;
		if (op) begin
			sa_i = (ae[4:0] != 5'd0) ? 1024 + int'(am[9:0]) : int'(am[9:0]);
			sb_i = (be[4:0] != 5'd0) ? 1024 + int'(bm[9:0]) : int'(bm[9:0]);
			eaf  = (ae[4:0] == 5'd0) ? 1 : int'(ae[4:0]);   // Subnormal counts as 1
			ebf  = (be[4:0] == 5'd0) ? 1 : int'(be[4:0]);
			r    = 23'(sa_i * sb_i);
			e    = exp_t'(eaf + ebf + 3);
			s    = as ^ bs;
		end else if (am == '0) begin
			r = {1'b0, bm};                 // a ignored
			e = be;
			s = bs;
		end else if (bm == '0) begin
			r = {1'b0, am};
			e = ae;
			s = as;
		end else begin
			if (ae >= be) begin
				big_m   = int'(am);
				small_m = int'(bm);
				big_s   = as;
				small_s = bs;
				diff    = int'(ae) - int'(be);
				e       = ae;
			end else begin
				big_m   = int'(bm);
				small_m = int'(am);
				big_s   = bs;
				small_s = as;
				diff    = int'(be) - int'(ae);
				e       = be;
			end
			small_m = (diff >= 22) ? 0 : (small_m >> diff);
			if (big_s == small_s) begin
				r = 23'(big_m + small_m);
				s = big_s;
			end else begin
				d = big_m - small_m;
				r = 23'((d < 0) ? -d : d);
				s = (d < 0) ? small_s : big_s;  // Sign follows the larger magnitude
			end
		end
		if (r == '0)
			return '0;
		sh = r;
		lz = 0;
		while (sh[22] == 1'b0) begin
			sh = sh << 1;
			lz++;
		end
		e = exp_t'(int'(e) + 1 - lz);
		return {s, e, sh[22:1]};
	endfunction

	task automatic report_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		$display("[FAIL] %0t ns: %s got 0x%0h, expected 0x%0h", $time, name, got, want);
		err_cnt++;
	endtask

	task automatic send(input logic op, input logic as, input exp_t ae, input man_t am,
			input logic bs, input exp_t be, input man_t bm);
		@(negedge clk);
		in_valid = 1'b1;
		op_mul   = op;
		a_sgn    = as;
		a_exp    = ae;
		a_man    = am;
		b_sgn    = bs;
		b_exp    = be;
		b_man    = bm;
		exp_q.push_back(expect_result(op, as, ae, am, bs, be, bm));
		iss_q.push_back(cyc);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			in_valid = 1'b0;
		end
	endtask

	// One item of test kind 1..4, kind 5 picks any of them
	task automatic gen_item(input int kind);
		int   k;
		int   lo;
		int   hi;
		int   eff;
		logic as;
		logic bs;
		exp_t ae;
		exp_t be;
		exp_t et;
		man_t am;
		man_t bm;
		k  = (kind == 5) ? urange(1, 4) : kind;
		as = urange(0, 1) == 1;
		bs = urange(0, 1) == 1;
		am = rand_man();
		bm = rand_man();
		ae = exp_t'(urange(11, 55));
		be = exp_t'(int'(ae) - urange(0, 3));   // Close exponents, either may be larger
		if (k <= 2 && urange(0, 2) == 0)
			be = exp_t'(urange(8, 55));          // Wide gaps, often 22 and up
		if (urange(0, 1) == 1) begin
			et = ae;
			ae = be;
			be = et;
		end
		case (k)
			1: bs = as;
			2: begin
				bs = ~as;
				if (urange(0, 7) == 0) begin
					be = ae;                     // Exact cancel
					bm = am;
				end
			end
			3: begin
				lo = urange(8, 54);
				hi = urange(lo + 1, 55);         // Zero operand holds the larger exponent
				if (urange(0, 1) == 1) begin
					am = '0;
					ae = exp_t'(hi);
					be = exp_t'(lo);
				end else begin
					bm = '0;
					be = exp_t'(hi);
					ae = exp_t'(lo);
				end
			end
			default: begin
				hi  = (urange(0, 3) == 0) ? 0 : urange(1, 31);
				eff = (hi == 0) ? 1 : hi;
				ae  = {1'(urange(0, 1)), 5'(hi)};  // Top exponent bit is junk
				if (hi == 0 && urange(0, 1) == 1)
					am[9:0] = '0;                // Zero significand
				lo  = (18 - eff < 0) ? 0 : 18 - eff;
				hi  = (56 - eff > 31) ? 31 : 56 - eff;
				be  = {1'(urange(0, 1)), 5'(urange(lo, hi))};
			end
		endcase
		send(k == 4, as, ae, am, bs, be, bm);
	endtask

	always @(posedge clk) begin
		cyc = cyc + 1;
		if (cyc >= TIMEOUT_CYC) begin
			$display("Timeout at cycle %0d, %0d queued items never came out", cyc, exp_q.size());
			$display("TB FAILED");
			$finish;
		end
	end

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!rst && out_valid) begin
			if (exp_q.size() == 0) begin
				$display("Output at %0t ns with no item left in the expected queue", $time);
				err_cnt++;
			end else begin
				exp_item = exp_q.pop_front();
				exp_cyc  = iss_q.pop_front();
				chk_cnt++;
				if (y_sgn !== exp_item[RES_W-1])
					report_value("y_sgn", 32'(y_sgn), 32'(exp_item[RES_W-1]));
				if (y_exp !== exp_item[RES_W-2 -: `FPALU_EXP_W])
					report_value("y_exp", 32'(y_exp), 32'(exp_item[RES_W-2 -: `FPALU_EXP_W]));
				if (y_man !== exp_item[`FPALU_MAN_W-1:0])
					report_value("y_man", 32'(y_man), 32'(exp_item[`FPALU_MAN_W-1:0]));
				if (cyc != exp_cyc + `FPALU_LAT)
					report_value("latency", cyc - exp_cyc, `FPALU_LAT);
			end
		end
	end

	initial begin
		seed     = 32'h2601;
		cyc      = 0;
		err_cnt  = 0;
		chk_cnt  = 0;
		clk      = 1'b0;
		rst      = 1'b1;
		in_valid = 1'b0;
		op_mul   = 1'b0;
		a_sgn    = 1'b0;
		a_exp    = '0;
		a_man    = '0;
		b_sgn    = 1'b0;
		b_exp    = '0;
		b_man    = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int t = 1; t <= N_TESTS; t++) begin
			errs_before = err_cnt;
			for (int i = 0; i < N_ITEMS; i++) begin
				if (t == 5 && urange(0, 7) == 0)
					idle(urange(1, 3));          // Bubble in the stream
				gen_item(t);
			end
			idle(1);
			while (exp_q.size() != 0)
				@(negedge clk);
			$display("Test %0d (%s): %0d items, %0d errors", t, test_name(t), N_ITEMS,
				err_cnt - errs_before);
		end
		idle(3);                                 // Nothing more may come out
		$display("Done: %0d tests, %0d results checked, %0d errors", N_TESTS, chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire
